// File: fft_power_dec_top.f
+incdir+verilog
verilog/fft_pkg.sv
verilog/fft_butterfly.sv
verilog/fft_stage.sv
verilog/fft_32.sv
verilog/fft_power.sv
verilog/power_dec.sv
verilog/fft_power_dec_top.sv
tb/fft_power_dec_props.sv
tb/tb_fft_power_dec_top.sv

// File: Bender.yml
package:
  name: fft_power_dec

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/fft_pkg.sv
      - verilog/fft_butterfly.sv
      - verilog/fft_stage.sv
      - verilog/fft_32.sv
      - verilog/fft_power.sv
      - verilog/power_dec.sv
      - verilog/fft_power_dec_top.sv
  - target: test
    files:
      - tb/fft_power_dec_props.sv
      - tb/tb_fft_power_dec_top.sv

// File: tb/tb_fft_power_dec_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_power_dec_defines.svh"

module tb_fft_power_dec_top
    import fft_pkg::*;
();

    localparam int  LAT_PWR     = 7;
    localparam int  N_B2B       = 200;
    localparam int  N_GAP       = 10;
    localparam int  N_FRZ       = 6;
    // Reset, idle, two directed frames, streams, three drains and a margin
    localparam int  TIMEOUT_CYC = 16 + 8 + 2 * (LAT_PWR + 4) + N_B2B + 3 * N_GAP
                                + 2 * N_FRZ + 3 * (LAT_PWR + 4) + 24;
    localparam real PI          = 3.14159265358979;

    logic    clk_fpga = 1'b0;
    logic    arstb;
    logic    freeze_i;
    logic    frame_valid_i;
    sample_t sample_i [`FFT_POINTS];
    logic    pwr_valid_o;
    pwr_t    pwr_o [`FFT_BINS];
    logic    dec_valid_o;
    dec_t    dec_o [`FFT_BINS];

    int      cyc = 0;
    int      err_pwr = 0;
    int      err_dec = 0;
    int      err_valid = 0;
    int      err_assert = 0;
    int      stamp;
    int      stamp_q [$];
    pwr_t    exp_pwr_q [$];
    dec_t    exp_dec_q [$];
    logic    frz_seen = 1'b0;
    logic    dec_pend = 1'b0;
    logic    dec_exp_valid;
    dec_t    pend_lvl [`FFT_BINS] = '{default: '0};
    dec_t    last_lvl [`FFT_BINS] = '{default: '0};
    sample_t frm [`FFT_POINTS];

    fft_power_dec_top i_fft_power_dec_top (
        .clk_fpga      (clk_fpga),
        .arstb         (arstb),
        .freeze_i      (freeze_i),
        .frame_valid_i (frame_valid_i),
        .sample_i      (sample_i),
        .pwr_valid_o   (pwr_valid_o),
        .pwr_o         (pwr_o),
        .dec_valid_o   (dec_valid_o),
        .dec_o         (dec_o)
    );

    always #10 clk_fpga = ~clk_fpga;

    // Freeze as the level register saw it on the last rising edge
    always @(posedge clk_fpga) begin
        cyc      <= cyc + 1;
        frz_seen <= freeze_i;
    end

    function automatic longint wrap_bin(input longint x);
        bin_t v;
        v = bin_t'(x);
        return v;
    endfunction

    function automatic void twiddle(input int k, output longint re, output longint im);
        re = int'(real'(1 << `TW_SHIFT) * $cos(2.0 * PI * k / 32.0));
        im = -int'(real'(1 << `TW_SHIFT) * $sin(2.0 * PI * k / 32.0));
    endfunction

    function automatic void fft_ref(input sample_t smp [`FFT_POINTS],
                                    output pwr_t pwr [`FFT_BINS],
                                    output dec_t lvl [`FFT_BINS]);
        longint re [`FFT_POINTS];
        longint im [`FFT_POINTS];
        longint wr, wi, tr, ti, p;
        int     rev, lo, hi, span, msb;
        for (int i = 0; i < `FFT_POINTS; i++) begin
            rev = 0;
            for (int n = 0; n < `FFT_STAGES; n++) begin
                if (i & (1 << n)) begin
                    rev += 1 << (`FFT_STAGES - 1 - n);
                end
            end
            re[i] = smp[rev];
            im[i] = 0;
        end
        for (int s = 0; s < `FFT_STAGES; s++) begin
            span = 1 << s;
            for (int g = 0; g < `FFT_POINTS; g += 2 * span) begin
                for (int j = 0; j < span; j++) begin
                    lo = g + j;
                    hi = lo + span;
                    twiddle(j * ((`FFT_POINTS / 2) >> s), wr, wi);
                    tr = (re[hi] * wr - im[hi] * wi) >>> `TW_SHIFT;
                    ti = (re[hi] * wi + im[hi] * wr) >>> `TW_SHIFT;
                    re[hi] = wrap_bin(re[lo] - tr);
                    im[hi] = wrap_bin(im[lo] - ti);
                    re[lo] = wrap_bin(re[lo] + tr);
                    im[lo] = wrap_bin(im[lo] + ti);
                end
            end
        end
        for (int k = 0; k < `FFT_BINS; k++) begin
            p = re[k] * re[k] + im[k] * im[k];
            msb = 0;
            while ((p >> (msb + 1)) != 0) begin
                msb++;
            end
            pwr[k] = pwr_t'(p);
            lvl[k] = (msb / 2 > 15) ? dec_t'(15) : dec_t'(msb / 2);
        end
    endfunction

    task automatic check_pwr(input int bin, input pwr_t got, input pwr_t exp);
        if (got !== exp) begin
            err_pwr++;
            $display("MISMATCH at %0t: pwr_o[%0d] = %0d, expected %0d", $time, bin, got, exp);
        end
    endtask

    task automatic check_dec(input int bin, input dec_t got, input dec_t exp);
        if (got !== exp) begin
            err_dec++;
            $display("MISMATCH at %0t: dec_o[%0d] = %0d, expected %0d", $time, bin, got, exp);
        end
    endtask

    task automatic send_frame(input sample_t smp [`FFT_POINTS]);
        pwr_t exp_pwr [`FFT_BINS];
        dec_t exp_lvl [`FFT_BINS];
        @(negedge clk_fpga);
        sample_i      = smp;
        frame_valid_i = 1'b1;
        fft_ref(smp, exp_pwr, exp_lvl);
        stamp_q.push_back(cyc);
        for (int k = 0; k < `FFT_BINS; k++) begin
            exp_pwr_q.push_back(exp_pwr[k]);
            exp_dec_q.push_back(exp_lvl[k]);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk_fpga);
            frame_valid_i = 1'b0;
        end
    endtask

    task automatic random_frame();
        for (int i = 0; i < `FFT_POINTS; i++) begin
            frm[i] = sample_t'($urandom);
        end
    endtask

    task automatic wait_pwr();
        do begin
            @(negedge clk_fpga);
        end while (pwr_valid_o !== 1'b1);
    endtask

    task automatic wait_drain();
        while (stamp_q.size() != 0 || dec_pend) begin
            @(negedge clk_fpga);
        end
        repeat (2) @(negedge clk_fpga);
    endtask

    always @(negedge clk_fpga) begin
        dec_exp_valid = dec_pend && !frz_seen;
        if (dec_valid_o !== dec_exp_valid) begin
            err_valid++;
            $display("MISMATCH at %0t: dec_valid_o = %b, expected %b",
                     $time, dec_valid_o, dec_exp_valid);
        end
        if (dec_exp_valid) begin
            last_lvl = pend_lvl;
        end
        // Levels follow the new frame or hold their last value
        for (int k = 0; k < `FFT_BINS; k++) begin
            check_dec(k, dec_o[k], last_lvl[k]);
        end
        dec_pend = 1'b0;
        if (pwr_valid_o === 1'b1) begin
            if (stamp_q.size() == 0) begin
                err_valid++;
                $display("pwr_valid_o went high at %0t with no frame in flight", $time);
            end else begin
                stamp = stamp_q.pop_front();
                if (cyc - stamp != LAT_PWR) begin
                    err_valid++;
                    $display("Power came %0d cycles after its frame at %0t", cyc - stamp, $time);
                end
                for (int k = 0; k < `FFT_BINS; k++) begin
                    check_pwr(k, pwr_o[k], exp_pwr_q.pop_front());
                    pend_lvl[k] = exp_dec_q.pop_front();
                end
                dec_pend = 1'b1;
            end
        end else if (stamp_q.size() != 0 && cyc - stamp_q[0] >= LAT_PWR) begin
            err_valid++;
            $display("No pwr_valid_o at %0t for the frame sent in cycle %0d", $time, stamp_q[0]);
            void'(stamp_q.pop_front());
            repeat (`FFT_BINS) begin
                void'(exp_pwr_q.pop_front());
                void'(exp_dec_q.pop_front());
            end
        end
    end

    initial begin
        while (cyc < TIMEOUT_CYC) begin
            @(posedge clk_fpga);
        end
        $display("Timeout after %0d cycles, the run did not finish", cyc);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'hc812_67c4));
        arstb         = 1'b0;
        freeze_i      = 1'b0;
        frame_valid_i = 1'b0;
        sample_i      = '{default: '0};
        repeat (16) @(negedge clk_fpga);
        arstb = 1'b1;
        // Every output reads zero while nothing has been sent
        repeat (8) begin
            @(negedge clk_fpga);
            for (int k = 0; k < `FFT_BINS; k++) begin
                check_pwr(k, pwr_o[k], '0);
                check_dec(k, dec_o[k], '0);
            end
        end
        // DC of 10 on all points sums to 320 in bin 0 only
        frm = '{default: sample_t'(10)};
        send_frame(frm);
        idle_cycles(1);
        wait_pwr();
        for (int k = 0; k < `FFT_BINS; k++) begin
            check_pwr(k, pwr_o[k], (k == 0) ? pwr_t'(320 * 320) : pwr_t'(0));
        end
        @(negedge clk_fpga);
        check_dec(0, dec_o[0], dec_t'(8));
        // An impulse spreads evenly over all bins
        frm = '{default: '0};
        frm[0] = sample_t'(100);
        send_frame(frm);
        idle_cycles(1);
        wait_pwr();
        for (int k = 0; k < `FFT_BINS; k++) begin
            check_pwr(k, pwr_o[k], pwr_t'(100 * 100));
        end
        @(negedge clk_fpga);
        for (int k = 0; k < `FFT_BINS; k++) begin
            check_dec(k, dec_o[k], dec_t'(6));
        end
        repeat (N_B2B) begin
            random_frame();
            send_frame(frm);
        end
        repeat (N_GAP) begin
            random_frame();
            send_frame(frm);
            idle_cycles($urandom % 3);
        end
        idle_cycles(1);
        wait_drain();
        freeze_i = 1'b1;
        repeat (N_FRZ) begin
            random_frame();
            send_frame(frm);
        end
        idle_cycles(1);
        wait_drain();
        freeze_i = 1'b0;
        repeat (N_FRZ) begin
            random_frame();
            send_frame(frm);
        end
        idle_cycles(1);
        wait_drain();
        err_assert = i_fft_power_dec_top.u_props_top.fail_cnt
                   + i_fft_power_dec_top.u_power_dec.u_props_dec.fail_cnt;
        $display("Errors: %0d power, %0d level, %0d valid, %0d assertion",
                 err_pwr, err_dec, err_valid, err_assert);
        if (err_pwr + err_dec + err_valid + err_assert == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/fft_power_dec_props.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_power_dec_defines.svh"

module fft_power_dec_props
    import fft_pkg::*;
#(
    parameter int PWR_LAT = 7
) (
    input logic clk_fpga,
    input logic arstb,
    input logic freeze_i,
    input logic src_valid_i,
    input logic pwr_valid_i,
    input logic dec_valid_i,
    input dec_t dec_i [`FFT_BINS]
);

    logic [`FFT_BINS*`DEC_W-1:0] dec_flat;
    int                          fail_cnt = 0;

    genvar k;
    generate
        for (k = 0; k < `FFT_BINS; k++) begin : g_flat
            assign dec_flat[k*`DEC_W +: `DEC_W] = dec_i[k];
        end
    endgenerate

    // Powers appear PWR_LAT clocks after the frame and levels one clock later
    generate
        if (PWR_LAT > 0) begin : g_lat
            assert property (@(posedge clk_fpga) disable iff (!arstb)
                src_valid_i |-> ##PWR_LAT pwr_valid_i)
                else begin
                    $error("Power result missing after its frame");
                    fail_cnt++;
                end
        end
    endgenerate

    assert property (@(posedge clk_fpga) disable iff (!arstb)
        src_valid_i ##PWR_LAT (pwr_valid_i && !freeze_i) |=> dec_valid_i)
        else begin
            $error("Level result missing after its power");
            fail_cnt++;
        end

    // A frozen display neither flags nor changes its levels
    assert property (@(posedge clk_fpga) disable iff (!arstb)
        freeze_i |=> !dec_valid_i && $stable(dec_flat))
        else begin
            $error("Levels changed while frozen");
            fail_cnt++;
        end

    assert property (@(posedge clk_fpga) !arstb |=> !pwr_valid_i && !dec_valid_i)
        else begin
            $error("A valid is high during reset");
            fail_cnt++;
        end

endmodule

bind fft_power_dec_top fft_power_dec_props #(
    .PWR_LAT (7)
) u_props_top (
    .clk_fpga    (clk_fpga),
    .arstb       (arstb),
    .freeze_i    (freeze_i),
    .src_valid_i (frame_valid_i),
    .pwr_valid_i (pwr_valid_o),
    .dec_valid_i (dec_valid_o),
    .dec_i       (dec_o)
);

bind power_dec fft_power_dec_props #(
    .PWR_LAT (0)
) u_props_dec (
    .clk_fpga    (clk_fpga),
    .arstb       (arstb),
    .freeze_i    (freeze_i),
    .src_valid_i (pwr_valid_i),
    .pwr_valid_i (pwr_valid_i),
    .dec_valid_i (dec_valid_o),
    .dec_i       (dec_o)
);

`default_nettype wire

// File: verilog/fft_power_dec_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_power_dec_defines.svh"

module fft_power_dec_top
    import fft_pkg::*;
(
    input  logic    clk_fpga,
    input  logic    arstb,
    input  logic    freeze_i,
    input  logic    frame_valid_i,
    input  sample_t sample_i [`FFT_POINTS],
    output logic    pwr_valid_o,
    output pwr_t    pwr_o [`FFT_BINS],
    output logic    dec_valid_o,
    output dec_t    dec_o [`FFT_BINS]
);

    logic rst_sync;
    logic bin_valid;
    bin_t bin_re [`FFT_POINTS];
    bin_t bin_im [`FFT_POINTS];

    // Holds the datapath clear for one clock after arstb rises
    always_ff @(posedge clk_fpga or negedge arstb) begin
        if (!arstb) begin
            rst_sync <= 1'b1;
        end else begin
            rst_sync <= 1'b0;
        end
    end

    fft_32 u_fft_32 (
        .clk_fpga      (clk_fpga),
        .arstb         (arstb),
        .rst_sync_i    (rst_sync),
        .frame_valid_i (frame_valid_i),
        .sample_i      (sample_i),
        .bin_valid_o   (bin_valid),
        .bin_re_o      (bin_re),
        .bin_im_o      (bin_im)
    );

    fft_power u_fft_power (
        .clk_fpga    (clk_fpga),
        .arstb       (arstb),
        .rst_sync_i  (rst_sync),
        .bin_valid_i (bin_valid),
        .bin_re_i    (bin_re),
        .bin_im_i    (bin_im),
        .pwr_valid_o (pwr_valid_o),
        .pwr_o       (pwr_o)
    );

    // Levels are taken from the registered powers one clock later
    power_dec u_power_dec (
        .clk_fpga    (clk_fpga),
        .arstb       (arstb),
        .rst_sync_i  (rst_sync),
        .freeze_i    (freeze_i),
        .pwr_valid_i (pwr_valid_o),
        .pwr_i       (pwr_o),
        .dec_valid_o (dec_valid_o),
        .dec_o       (dec_o)
    );

endmodule

`default_nettype wire

// File: verilog/power_dec.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_power_dec_defines.svh"

module power_dec
    import fft_pkg::*;
(
    input  logic clk_fpga,
    input  logic arstb,
    input  logic rst_sync_i,
    input  logic freeze_i,
    input  logic pwr_valid_i,
    input  pwr_t pwr_i [`FFT_BINS],
    output logic dec_valid_o,
    output dec_t dec_o [`FFT_BINS]
);

    localparam int LVL_MAX = (1 << `DEC_W) - 1;

    // Level is half the position of the leading one and rises about 6 dB per step
    function automatic dec_t level_of(input pwr_t p);
        int top;
        top = 0;
        for (int n = 0; n < `PWR_W; n++) begin
            if (p[n]) begin
                top = n;
            end
        end
        if (top / 2 > LVL_MAX) begin
            return dec_t'(LVL_MAX);
        end
        return dec_t'(top / 2);
    endfunction

    logic update;

    assign update = pwr_valid_i && !freeze_i;

    always_ff @(posedge clk_fpga or negedge arstb) begin
        if (!arstb) begin
            dec_valid_o <= 1'b0;
            dec_o       <= '{default: '0};
        end else if (rst_sync_i) begin
            dec_valid_o <= 1'b0;
            dec_o       <= '{default: '0};
        end else begin
            dec_valid_o <= update;
            // A frozen display keeps the last levels
            if (update) begin
                for (int k = 0; k < `FFT_BINS; k++) begin
                    dec_o[k] <= level_of(pwr_i[k]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fft_power.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_power_dec_defines.svh"

module fft_power
    import fft_pkg::*;
(
    input  logic clk_fpga,
    input  logic arstb,
    input  logic rst_sync_i,
    input  logic bin_valid_i,
    input  bin_t bin_re_i [`FFT_POINTS],
    input  bin_t bin_im_i [`FFT_POINTS],
    output logic pwr_valid_o,
    output pwr_t pwr_o [`FFT_BINS]
);

    // Two squares of 16 bits sum to at most 2^31 and need one sign bit on top
    logic signed [2*`BIN_W:0] mag [`FFT_BINS];

    genvar k;
    generate
        // Upper bins mirror the lower ones for a real input and are not kept
        for (k = 0; k < `FFT_BINS; k++) begin : g_mag
            assign mag[k] = bin_re_i[k] * bin_re_i[k] + bin_im_i[k] * bin_im_i[k];
        end
    endgenerate

    always_ff @(posedge clk_fpga or negedge arstb) begin
        if (!arstb) begin
            pwr_valid_o <= 1'b0;
            pwr_o       <= '{default: '0};
        end else if (rst_sync_i) begin
            pwr_valid_o <= 1'b0;
            pwr_o       <= '{default: '0};
        end else begin
            pwr_valid_o <= bin_valid_i;
            if (bin_valid_i) begin
                for (int n = 0; n < `FFT_BINS; n++) begin
                    pwr_o[n] <= pwr_t'(mag[n]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fft_32.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_power_dec_defines.svh"

module fft_32
    import fft_pkg::*;
(
    input  logic    clk_fpga,
    input  logic    arstb,
    input  logic    rst_sync_i,
    input  logic    frame_valid_i,
    input  sample_t sample_i [`FFT_POINTS],
    output logic    bin_valid_o,
    output bin_t    bin_re_o [`FFT_POINTS],
    output bin_t    bin_im_o [`FFT_POINTS]
);

    function automatic int bit_rev(input int idx);
        int r;
        r = 0;
        for (int n = 0; n < `FFT_STAGES; n++) begin
            r = (r << 1) | ((idx >> n) & 1);
        end
        return r;
    endfunction

    sample_t sample_q [`FFT_POINTS];
    logic    frame_valid_q;

    // Index 0 is the reordered input, index s+1 the output of stage s
    bin_t stage_re    [`FFT_STAGES+1][`FFT_POINTS];
    bin_t stage_im    [`FFT_STAGES+1][`FFT_POINTS];
    logic stage_valid [`FFT_STAGES+1];

    always_ff @(posedge clk_fpga or negedge arstb) begin
        if (!arstb) begin
            frame_valid_q <= 1'b0;
            sample_q      <= '{default: '0};
        end else if (rst_sync_i) begin
            frame_valid_q <= 1'b0;
            sample_q      <= '{default: '0};
        end else begin
            frame_valid_q <= frame_valid_i;
            if (frame_valid_i) begin
                sample_q <= sample_i;
            end
        end
    end

    genvar i;
    genvar s;
    generate
        // Real input in bit-reversed order, sign extended to the bin width
        for (i = 0; i < `FFT_POINTS; i++) begin : g_reorder
            assign stage_re[0][i] = bin_t'(sample_q[bit_rev(i)]);
            assign stage_im[0][i] = '0;
        end

        for (s = 0; s < `FFT_STAGES; s++) begin : g_stage
            fft_stage #(
                .STAGE (s)
            ) u_stage (
                .clk_fpga   (clk_fpga),
                .arstb      (arstb),
                .rst_sync_i (rst_sync_i),
                .valid_i    (stage_valid[s]),
                .re_i       (stage_re[s]),
                .im_i       (stage_im[s]),
                .valid_o    (stage_valid[s+1]),
                .re_o       (stage_re[s+1]),
                .im_o       (stage_im[s+1])
            );
        end
    endgenerate

    assign stage_valid[0] = frame_valid_q;

    assign bin_valid_o = stage_valid[`FFT_STAGES];
    assign bin_re_o    = stage_re[`FFT_STAGES];
    assign bin_im_o    = stage_im[`FFT_STAGES];

endmodule

`default_nettype wire

// File: verilog/fft_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_power_dec_defines.svh"

module fft_stage
    import fft_pkg::*;
#(
    parameter int STAGE = 0
) (
    input  logic clk_fpga,
    input  logic arstb,
    input  logic rst_sync_i,
    input  logic valid_i,
    input  bin_t re_i [`FFT_POINTS],
    input  bin_t im_i [`FFT_POINTS],
    output logic valid_o,
    output bin_t re_o [`FFT_POINTS],
    output bin_t im_o [`FFT_POINTS]
);

    localparam int HALF_N = `FFT_POINTS / 2;
    // Distance between the two inputs of a butterfly
    localparam int SPAN   = 1 << STAGE;

    genvar b;
    generate
        for (b = 0; b < HALF_N; b++) begin : g_bfly
            localparam int J   = b % SPAN;
            localparam int TOP = (b / SPAN) * 2 * SPAN + J;
            localparam int BOT = TOP + SPAN;
            localparam logic [2*`TW_W-1:0] TW = twiddle_lookup(J * (HALF_N >> STAGE));
            localparam tw_t W_RE = TW[2*`TW_W-1:`TW_W];
            localparam tw_t W_IM = TW[`TW_W-1:0];

            fft_butterfly u_bfly (
                .clk_fpga (clk_fpga),
                .arstb    (arstb),
                .a_re_i   (re_i[TOP]),
                .a_im_i   (im_i[TOP]),
                .b_re_i   (re_i[BOT]),
                .b_im_i   (im_i[BOT]),
                .w_re_i   (W_RE),
                .w_im_i   (W_IM),
                .p_re_o   (re_o[TOP]),
                .p_im_o   (im_o[TOP]),
                .q_re_o   (re_o[BOT]),
                .q_im_o   (im_o[BOT])
            );
        end
    endgenerate

    // The valid bit follows the butterfly registers
    always_ff @(posedge clk_fpga or negedge arstb) begin
        if (!arstb) begin
            valid_o <= 1'b0;
        end else if (rst_sync_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fft_butterfly.sv
`timescale 1ns/100ps
`default_nettype none

`include "fft_power_dec_defines.svh"

module fft_butterfly
    import fft_pkg::*;
(
    input  logic clk_fpga,
    input  logic arstb,
    input  bin_t a_re_i,
    input  bin_t a_im_i,
    input  bin_t b_re_i,
    input  bin_t b_im_i,
    input  tw_t  w_re_i,
    input  tw_t  w_im_i,
    output bin_t p_re_o,
    output bin_t p_im_o,
    output bin_t q_re_o,
    output bin_t q_im_o
);

    localparam int PROD_W = `BIN_W + `TW_W + 1;

    logic signed [PROD_W-1:0] mul_re;
    logic signed [PROD_W-1:0] mul_im;
    bin_t                     t_re;
    bin_t                     t_im;

    // The complex product b * w stays at full width until the shift
    assign mul_re = b_re_i * w_re_i - b_im_i * w_im_i;
    assign mul_im = b_re_i * w_im_i + b_im_i * w_re_i;

    // Dropping the fraction bits floors the product and the upper bits wrap
    assign t_re = mul_re[`TW_SHIFT +: `BIN_W];
    assign t_im = mul_im[`TW_SHIFT +: `BIN_W];

    always_ff @(posedge clk_fpga or negedge arstb) begin
        if (!arstb) begin
            p_re_o <= '0;
            p_im_o <= '0;
            q_re_o <= '0;
            q_im_o <= '0;
        end else begin
            p_re_o <= a_re_i + t_re;
            p_im_o <= a_im_i + t_im;
            q_re_o <= a_re_i - t_re;
            q_im_o <= a_im_i - t_im;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fft_pkg.sv
`default_nettype none

`include "fft_power_dec_defines.svh"

package fft_pkg;

    typedef logic signed [`SAMPLE_W-1:0] sample_t;
    typedef logic signed [`BIN_W-1:0]    bin_t;
    typedef logic signed [`TW_W-1:0]     tw_t;
    typedef logic        [`PWR_W-1:0]    pwr_t;
    typedef logic        [`DEC_W-1:0]    dec_t;

    // Quarter wave of the cosine holds round(256 * cos(2*pi*k/32)) for k = 0 to 8
    localparam tw_t COS_Q [0:8] = '{256, 251, 237, 213, 181, 142, 98, 50, 0};

    // Returns {cos, -sin} of W32^k for k = 0 to 15
    function automatic logic [2*`TW_W-1:0] twiddle_lookup(input int unsigned k);
        tw_t w_re;
        tw_t w_im;
        if (k <= 8) begin
            w_re = COS_Q[k];
            w_im = -COS_Q[8 - k];
        end else begin
            // Second quadrant mirrors the first
            w_re = -COS_Q[16 - k];
            w_im = -COS_Q[k - 8];
        end
        return {w_re, w_im};
    endfunction

endpackage

`default_nettype wire

// File: verilog/fft_power_dec_defines.svh
`ifndef FFT_POWER_DEC_DEFINES_SVH
`define FFT_POWER_DEC_DEFINES_SVH

// Frame and spectrum size
`define FFT_POINTS 32
`define FFT_BINS   17
`define FFT_STAGES 5

// Datapath widths
`define SAMPLE_W   8
`define BIN_W      16
`define PWR_W      35
`define DEC_W      4

// Twiddles are signed fixed point in which 256 stands for 1.0
`define TW_W       10
`define TW_SHIFT   8

`endif
